/* logic/adc_pkg.sv */
package adc_pkg;

    // interleaving and code width
    localparam int n_slices = 16;
    localparam int adc_bits = 8;

    // two guard bits hold +/-mag minus offset without wrapping
    localparam int unfold_bits = adc_bits + 2;

    // signed code range after saturation
    localparam int code_max = 2 ** (adc_bits - 1) - 1;
    localparam int code_min = -(2 ** (adc_bits - 1));

    typedef logic signed [adc_bits-1:0] adc_code_t;

    // raw sign-magnitude frame from the slices
    typedef struct packed {
        logic                               valid;
        logic [n_slices-1:0]                sign;
        logic [n_slices-1:0][adc_bits-1:0]  mag;
    } adc_raw_frame_t;

    // unfolded signed frame
    typedef struct packed {
        logic                       valid;
        adc_code_t [n_slices-1:0]   code;
    } adc_code_frame_t;

    // one decision bit per slice, bit 0 earliest
    typedef logic [n_slices-1:0] rx_word_t;

endpackage

/* logic/prbs_pkg.sv */
package prbs_pkg;

    import adc_pkg::*;

    // PRBS7, x[n] = x[n-6] ^ x[n-7]
    localparam int prbs_order = 7;
    localparam int prbs_tap_a = 6;
    localparam int prbs_tap_b = 7;

    localparam int count_bits = 32;

    // enough bits to count every slice of one word
    localparam int pop_bits = $clog2(n_slices + 1);

    typedef enum logic {
        src_adc  = 1'b0,
        src_bist = 1'b1
    } prbs_src_e;

    typedef enum logic [1:0] {
        mode_clear  = 2'd0,
        mode_run    = 2'd1,
        mode_freeze = 2'd2
    } chk_mode_e;

    typedef struct packed {
        logic                gen_en;
        logic                inj_err;
        prbs_src_e           src;
        chk_mode_e           mode;
        logic [n_slices-1:0] mask;
    } prbs_cfg_t;

    typedef struct packed {
        logic [count_bits-1:0] err_count;
        logic [count_bits-1:0] total_count;
    } prbs_result_t;

endpackage

/* logic/adc_unfold.sv */
`timescale 1ns/1ps

module adc_unfold import adc_pkg::*; (
    input  logic            clk_adc,
    input  logic            cdr_rstb,
    input  adc_raw_frame_t  frame_i,
    input  adc_code_t       offset_i,
    output adc_code_frame_t frame_o
);

    logic                     valid_q;
    adc_code_t [n_slices-1:0] code_d;
    adc_code_t [n_slices-1:0] code_q;

    // sign 1 means positive, then offset removal and clamp
    function automatic adc_code_t unfold_code(
        input logic                sign,
        input logic [adc_bits-1:0] mag,
        input adc_code_t           offset
    );
        logic signed [unfold_bits-1:0] value;
        value = $signed({{(unfold_bits - adc_bits){1'b0}}, mag});
        if (!sign) begin
            value = -value;
        end
        value = value - offset;
        if (value > code_max) begin
            return adc_code_t'(code_max);
        end else if (value < code_min) begin
            return adc_code_t'(code_min);
        end
        return adc_code_t'(value);
    endfunction

    always_comb begin
        for (int i = 0; i < n_slices; i++) begin
            code_d[i] = unfold_code(frame_i.sign[i], frame_i.mag[i], offset_i);
        end
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= frame_i.valid;
        end
    end

    always_ff @(posedge clk_adc) begin
        code_q <= code_d;
    end

    assign frame_o.valid = valid_q;
    assign frame_o.code  = code_q;

endmodule

/* logic/data_slicer.sv */
`timescale 1ns/1ps

module data_slicer import adc_pkg::*; (
    input  logic            clk_adc,
    input  logic            cdr_rstb,
    input  adc_code_frame_t frame_i,
    input  adc_code_t       thresh_i,
    output rx_word_t        word_o,
    output logic            valid_o
);

    rx_word_t decision;
    rx_word_t word_q;
    logic     valid_q;

    // strict compare, a code equal to the threshold reads as 0
    always_comb begin
        for (int i = 0; i < n_slices; i++) begin
            decision[i] = frame_i.code[i] > thresh_i;
        end
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= frame_i.valid;
        end
    end

    always_ff @(posedge clk_adc) begin
        word_q <= decision;
    end

    assign word_o  = word_q;
    assign valid_o = valid_q;

endmodule

/* logic/prbs_generator.sv */
`timescale 1ns/1ps

module prbs_generator import adc_pkg::*, prbs_pkg::*; (
    input  logic     clk_adc,
    input  logic     cdr_rstb,
    input  logic     en_i,
    input  logic     inj_err_i,
    output rx_word_t word_o,
    output logic     valid_o
);

    // seq[prbs_order-1:0] is the stored history, seq[6] the newest bit
    logic [prbs_order-1:0]          state_q;
    logic [prbs_order+n_slices-1:0] seq;
    rx_word_t                       word_q;
    logic                           valid_q;

    // sixteen serial steps unrolled
    function automatic logic [prbs_order+n_slices-1:0] extend(
        input logic [prbs_order-1:0] hist
    );
        logic [prbs_order+n_slices-1:0] s;
        s = '0;
        s[prbs_order-1:0] = hist;
        for (int i = prbs_order; i < prbs_order + n_slices; i++) begin
            s[i] = s[i - prbs_tap_a] ^ s[i - prbs_tap_b];
        end
        return s;
    endfunction

    assign seq = extend(state_q);

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            state_q <= '1;
            valid_q <= 1'b0;
        end else begin
            valid_q <= en_i;
            if (en_i) begin
                state_q <= seq[prbs_order+n_slices-1 -: prbs_order];
            end
        end
    end

    // injected error flips bit 0 of the outgoing word only
    always_ff @(posedge clk_adc) begin
        if (en_i) begin
            word_q <= seq[prbs_order +: n_slices] ^ rx_word_t'(inj_err_i);
        end
    end

    assign word_o  = word_q;
    assign valid_o = valid_q;

endmodule

/* logic/prbs_checker.sv */
`timescale 1ns/1ps

module prbs_checker import adc_pkg::*, prbs_pkg::*; (
    input  logic         clk_adc,
    input  logic         cdr_rstb,
    input  rx_word_t     adc_word_i,
    input  logic         adc_valid_i,
    input  rx_word_t     bist_word_i,
    input  logic         bist_valid_i,
    input  prbs_cfg_t    cfg_i,
    output prbs_result_t result_o
);

    rx_word_t                       rx_word;
    logic                           rx_valid;
    logic [prbs_order-1:0]          hist_q;
    logic [prbs_order+n_slices-1:0] seq;
    rx_word_t                       pred;
    rx_word_t                       err_vec;
    logic [pop_bits-1:0]            err_pop;
    logic [pop_bits-1:0]            mask_pop;
    logic [count_bits-1:0]          err_q;
    logic [count_bits-1:0]          total_q;

    function automatic logic [pop_bits-1:0] popcount(input rx_word_t w);
        logic [pop_bits-1:0] n;
        n = '0;
        for (int i = 0; i < n_slices; i++) begin
            n = n + pop_bits'(w[i]);
        end
        return n;
    endfunction

    // source select
    assign rx_word  = (cfg_i.src == src_bist) ? bist_word_i : adc_word_i;
    assign rx_valid = (cfg_i.src == src_bist) ? bist_valid_i : adc_valid_i;

    // received history below, new word above, bit 0 earliest
    assign seq = {rx_word, hist_q};

    // prediction taps come from received bits, so no seed is needed
    always_comb begin
        for (int i = 0; i < n_slices; i++) begin
            pred[i] = seq[prbs_order + i - prbs_tap_a] ^ seq[prbs_order + i - prbs_tap_b];
        end
    end

    assign err_vec  = (rx_word ^ pred) & cfg_i.mask;
    assign err_pop  = popcount(err_vec);
    assign mask_pop = popcount(cfg_i.mask);

    // history follows the stream in every mode
    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            hist_q <= '0;
        end else if (rx_valid) begin
            hist_q <= rx_word[n_slices-1 -: prbs_order];
        end
    end

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            err_q   <= '0;
            total_q <= '0;
        end else begin
            case (cfg_i.mode)
                mode_clear: begin
                    err_q   <= '0;
                    total_q <= '0;
                end
                mode_run: begin
                    if (rx_valid) begin
                        err_q   <= err_q + count_bits'(err_pop);
                        total_q <= total_q + count_bits'(mask_pop);
                    end
                end
                default: begin
                    // freeze
                    err_q   <= err_q;
                    total_q <= total_q;
                end
            endcase
        end
    end

    assign result_o.err_count   = err_q;
    assign result_o.total_count = total_q;

endmodule

/* logic/rx_prbs_top.sv */
`timescale 1ns/1ps

module rx_prbs_top import adc_pkg::*, prbs_pkg::*; (
    input  logic            clk_adc,
    input  logic            cdr_rstb,
    input  adc_raw_frame_t  adc_frame_i,
    input  adc_code_t       offset_i,
    input  adc_code_t       thresh_i,
    input  prbs_cfg_t       cfg_i,
    output adc_code_frame_t code_frame_o,
    output rx_word_t        rx_word_o,
    output logic            rx_valid_o,
    output prbs_result_t    result_o
);

    adc_code_frame_t code_frame;
    rx_word_t        rx_word;
    logic            rx_valid;
    rx_word_t        bist_word;
    logic            bist_valid;

    // receive path
    adc_unfold i_adc_unfold (
        .clk_adc  (clk_adc),
        .cdr_rstb (cdr_rstb),
        .frame_i  (adc_frame_i),
        .offset_i (offset_i),
        .frame_o  (code_frame)
    );

    data_slicer i_data_slicer (
        .clk_adc  (clk_adc),
        .cdr_rstb (cdr_rstb),
        .frame_i  (code_frame),
        .thresh_i (thresh_i),
        .word_o   (rx_word),
        .valid_o  (rx_valid)
    );

    // BIST source
    prbs_generator i_prbs_generator (
        .clk_adc   (clk_adc),
        .cdr_rstb  (cdr_rstb),
        .en_i      (cfg_i.gen_en),
        .inj_err_i (cfg_i.inj_err),
        .word_o    (bist_word),
        .valid_o   (bist_valid)
    );

    prbs_checker i_prbs_checker (
        .clk_adc      (clk_adc),
        .cdr_rstb     (cdr_rstb),
        .adc_word_i   (rx_word),
        .adc_valid_i  (rx_valid),
        .bist_word_i  (bist_word),
        .bist_valid_i (bist_valid),
        .cfg_i        (cfg_i),
        .result_o     (result_o)
    );

    assign code_frame_o = code_frame;
    assign rx_word_o    = rx_word;
    assign rx_valid_o   = rx_valid;

endmodule

/* verif/tb_checks.svh */
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// outputs idle right after reset
reset_idle_chk: assert property (@(posedge clk_adc)
    idle_chk |-> (!rx_valid_o && !code_frame_o.valid && result_o == '0))
    else begin
        err_reset = err_reset + 1;
        $display("[ERROR] %0t rx_valid_o/code_frame_o.valid/result_o exp=0/0/0 got=%0b/%0b/%h",
                 $time, $sampled(rx_valid_o), $sampled(code_frame_o.valid), $sampled(result_o));
    end

// unfold, one cycle after the frame
code_valid_chk: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
    code_frame_o.valid == exp_code_vld)
    else begin
        err_unfold = err_unfold + 1;
        $display("[ERROR] %0t code_frame_o.valid exp=%0b got=%0b",
                 $time, $sampled(exp_code_vld), $sampled(code_frame_o.valid));
    end

code_value_chk: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
    exp_code_vld |-> code_frame_o.code == exp_code)
    else begin
        err_unfold = err_unfold + 1;
        $display("[ERROR] %0t code_frame_o.code exp=%h got=%h",
                 $time, $sampled(exp_code), $sampled(code_frame_o.code));
    end

// slicer, two cycles after the frame
slice_chk: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
    (rx_valid_o == exp_word_vld) && (!exp_word_vld || rx_word_o == exp_word))
    else begin
        err_slice = err_slice + 1;
        $display("[ERROR] %0t rx_word_o exp=%0b/%h got=%0b/%h", $time, $sampled(exp_word_vld),
                 $sampled(exp_word), $sampled(rx_valid_o), $sampled(rx_word_o));
    end

counter_chk: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
    result_o.err_count == exp_err && result_o.total_count == exp_total)
    else begin
        err_count = err_count + 1;
        $display("[ERROR] %0t result_o exp=%h/%h got=%h/%h", $time, $sampled(exp_err),
                 $sampled(exp_total), $sampled(result_o.err_count),
                 $sampled(result_o.total_count));
    end

freeze_chk: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
    cfg_i.mode == mode_freeze |=> $stable(result_o))
    else begin
        err_mode = err_mode + 1;
        $display("[ERROR] %0t result_o exp=%h got=%h", $time, $past(result_o), $sampled(result_o));
    end

clear_chk: assert property (@(posedge clk_adc) disable iff (!cdr_rstb)
    cfg_i.mode == mode_clear |=> result_o == '0)
    else begin
        err_mode = err_mode + 1;
        $display("[ERROR] %0t result_o exp=0 got=%h", $time, $sampled(result_o));
    end

`endif

/* verif/tb_rx_prbs_top.sv */
`timescale 1ns/1ps

module tb_rx_prbs_top import adc_pkg::*, prbs_pkg::*; ();

    localparam int clk_period = 20;
    localparam int n_rand     = 200;
    localparam int n_sync     = 8;
    localparam int n_prbs     = 100;
    localparam int n_hold     = 20;
    localparam int n_bist     = 150;

    // reset, idle, all phases and drain, plus margin
    localparam int run_cycles = 16 + 4 + n_rand + n_sync + 2 * n_prbs + 2 * n_hold + 5
                              + 4 + n_bist + 1 + 4 + 4 + 8;
    localparam int watchdog_ns = (run_cycles + 200) * clk_period;

    logic            clk_adc;
    logic            cdr_rstb;
    adc_raw_frame_t  adc_frame_i;
    adc_code_t       offset_i;
    adc_code_t       thresh_i;
    prbs_cfg_t       cfg_i;
    adc_code_frame_t code_frame_o;
    rx_word_t        rx_word_o;
    logic            rx_valid_o;
    prbs_result_t    result_o;

    // reference model state
    adc_code_t [n_slices-1:0] exp_code;
    logic                     exp_code_vld;
    rx_word_t                 exp_word;
    logic                     exp_word_vld;
    logic                     gen_vld_q;
    logic                     inj_q;
    logic                     sel_vld;
    logic [count_bits-1:0]    exp_err;
    logic [count_bits-1:0]    exp_total;
    logic                     idle_chk;
    logic [prbs_order-1:0]    ref_hist;
    logic [31:0]              rng;

    int err_reset;
    int err_unfold;
    int err_slice;
    int err_count;
    int err_mode;
    int inj_pulses;

    rx_prbs_top i_rx_prbs_top (
        .clk_adc      (clk_adc),
        .cdr_rstb     (cdr_rstb),
        .adc_frame_i  (adc_frame_i),
        .offset_i     (offset_i),
        .thresh_i     (thresh_i),
        .cfg_i        (cfg_i),
        .code_frame_o (code_frame_o),
        .rx_word_o    (rx_word_o),
        .rx_valid_o   (rx_valid_o),
        .result_o     (result_o)
    );

    always #10 clk_adc = ~clk_adc;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] s;
        s = x;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // sign 1 is +mag, then subtract offset and clamp to the code range
    function automatic adc_code_t unfolded_value(
        input logic                sign,
        input logic [adc_bits-1:0] mag,
        input adc_code_t           offset
    );
        int v;
        v = sign ? int'(mag) : -int'(mag);
        v = v - int'(offset);
        if (v > code_max) begin
            v = code_max;
        end
        if (v < code_min) begin
            v = code_min;
        end
        return adc_code_t'(v);
    endfunction

    assign sel_vld = (cfg_i.src == src_bist) ? gen_vld_q : exp_word_vld;

    always_ff @(posedge clk_adc or negedge cdr_rstb) begin
        if (!cdr_rstb) begin
            exp_code_vld <= 1'b0;
            exp_word_vld <= 1'b0;
            gen_vld_q    <= 1'b0;
            inj_q        <= 1'b0;
            exp_err      <= '0;
            exp_total    <= '0;
        end else begin
            exp_code_vld <= adc_frame_i.valid;
            exp_word_vld <= exp_code_vld;
            gen_vld_q    <= cfg_i.gen_en;
            if (cfg_i.gen_en) begin
                inj_q <= cfg_i.inj_err;
            end
            if (cfg_i.mode == mode_clear) begin
                exp_err   <= '0;
                exp_total <= '0;
            end else if (cfg_i.mode == mode_run && sel_vld) begin
                exp_total <= exp_total + count_bits'($countones(cfg_i.mask));
                // a flipped bit 0 also spoils bits 6 and 7 of the same word
                if (cfg_i.src == src_bist && inj_q) begin
                    exp_err <= exp_err + count_bits'(3);
                end
            end
        end
    end

    always_ff @(posedge clk_adc) begin
        for (int i = 0; i < n_slices; i++) begin
            exp_code[i] <= unfolded_value(adc_frame_i.sign[i], adc_frame_i.mag[i], offset_i);
            exp_word[i] <= $signed(exp_code[i]) > $signed(thresh_i);
        end
    end

    `include "tb_checks.svh"

    // random signs, magnitudes, offsets and thresholds
    task automatic drive_random_frames(input int n);
        adc_raw_frame_t f;
        for (int k = 0; k < n; k++) begin
            @(posedge clk_adc);
            rng = xorshift32(rng);
            f.valid = rng[0] | rng[1];
            offset_i <= adc_code_t'(rng[15:8]);
            thresh_i <= adc_code_t'(rng[23:16]);
            for (int i = 0; i < n_slices; i++) begin
                rng = xorshift32(rng);
                f.sign[i] = rng[31];
                f.mag[i]  = rng[7:0];
            end
            adc_frame_i <= f;
        end
    endtask

    // signs follow the reference PRBS7 stream, bit 0 earliest
    task automatic drive_prbs_frames(input int n);
        adc_raw_frame_t f;
        logic           b;
        for (int k = 0; k < n; k++) begin
            @(posedge clk_adc);
            f.valid = 1'b1;
            for (int i = 0; i < n_slices; i++) begin
                b = ref_hist[prbs_tap_a-1] ^ ref_hist[prbs_tap_b-1];
                ref_hist = {ref_hist[prbs_order-2:0], b};
                rng = xorshift32(rng);
                f.sign[i] = b;
                f.mag[i]  = rng[7:0] | 8'h40;
            end
            adc_frame_i <= f;
        end
    endtask

    task automatic run_bist(input int n);
        for (int k = 0; k < n; k++) begin
            @(posedge clk_adc);
            rng = xorshift32(rng);
            cfg_i.inj_err <= (rng[3:0] == 4'd0);
            if (rng[3:0] == 4'd0) begin
                inj_pulses = inj_pulses + 1;
            end
        end
        @(posedge clk_adc);
        cfg_i.inj_err <= 1'b0;
    endtask

    initial begin
        rng         = 32'hc051_aa04;
        ref_hist    = '1;
        err_reset   = 0;
        err_unfold  = 0;
        err_slice   = 0;
        err_count   = 0;
        err_mode    = 0;
        inj_pulses  = 0;
        clk_adc     = 1'b0;
        cdr_rstb    = 1'b0;
        idle_chk    = 1'b0;
        adc_frame_i = '0;
        // frames offered during reset must not reach the outputs
        adc_frame_i.valid = 1'b1;
        offset_i    = '0;
        thresh_i    = '0;
        cfg_i       = '0;
        cfg_i.mode  = mode_run;
        cfg_i.mask  = '1;
        repeat (16) @(posedge clk_adc);
        cdr_rstb          <= 1'b1;
        idle_chk          <= 1'b1;
        adc_frame_i.valid <= 1'b0;
        repeat (4) @(posedge clk_adc);
        idle_chk   <= 1'b0;
        cfg_i.mode <= mode_clear;
        drive_random_frames(n_rand);
        offset_i <= '0;
        thresh_i <= '0;
        // checker history locks onto the stream while cleared
        drive_prbs_frames(n_sync);
        cfg_i.mode <= mode_run;
        drive_prbs_frames(n_prbs);
        cfg_i.mask <= 16'h5a3c;
        drive_prbs_frames(n_prbs);
        cfg_i.mode <= mode_freeze;
        drive_prbs_frames(n_hold);
        cfg_i.mode <= mode_run;
        drive_prbs_frames(n_hold);
        cfg_i.mode <= mode_clear;
        drive_prbs_frames(5);
        adc_frame_i.valid <= 1'b0;
        cfg_i.src         <= src_bist;
        cfg_i.mask        <= '1;
        cfg_i.gen_en      <= 1'b1;
        repeat (4) @(posedge clk_adc);
        cfg_i.mode <= mode_run;
        run_bist(n_bist);
        repeat (4) @(posedge clk_adc);
        cfg_i.mode <= mode_freeze;
        repeat (4) @(posedge clk_adc);
        cfg_i.gen_en <= 1'b0;
        repeat (8) @(posedge clk_adc);
        // each injected bit costs itself and its two tap uses
        assert (result_o.err_count == count_bits'(3 * inj_pulses)) else begin
            err_count = err_count + 1;
            $display("[ERROR] %0t result_o.err_count exp=%0d got=%0d",
                     $time, 3 * inj_pulses, result_o.err_count);
        end
        $display("errors: reset=%0d unfold=%0d slice=%0d count=%0d mode=%0d (injections=%0d)",
                 err_reset, err_unfold, err_slice, err_count, err_mode, inj_pulses);
        if (err_reset + err_unfold + err_slice + err_count + err_mode == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(watchdog_ns);
        $display("watchdog expired before the test sequence finished");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

/* project.f */
+incdir+verif
logic/adc_pkg.sv
logic/prbs_pkg.sv
logic/adc_unfold.sv
logic/data_slicer.sv
logic/prbs_generator.sv
logic/prbs_checker.sv
logic/rx_prbs_top.sv
verif/tb_rx_prbs_top.sv

/* Makefile */
# Verilator build and run for the receive PRBS testbench

VERILATOR ?= verilator
TOP       ?= tb_rx_prbs_top
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -Wno-fatal

FILELIST := project.f
SOURCES  := $(shell grep -v '^+' $(FILELIST)) verif/tb_checks.svh
SIM      := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "SIMULATION PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
